// File: list.f
source/fetch_pkg.sv
source/predict_pkg.sv
source/pc_gen.sv
source/branch_history.sv
source/target_buffer.sv
source/imem_arbiter.sv
source/fetch_top.sv
sim/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch stage regression with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module fetch_tb -f list.f -o fetch_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi

exit 0

// File: sim/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    localparam int load_cycles   = int'(fetch_pkg::imem_depth);
    localparam int walk_cycles   = 200;
    localparam int hold_cycles   = 20;
    localparam int drip_cycles   = 40;
    localparam int train_cycles  = 22;
    localparam int random_cycles = 600;
    localparam int total_cycles  = load_cycles + walk_cycles + hold_cycles + drip_cycles
                                   + train_cycles + random_cycles;
    localparam int timeout_limit = 2 * total_cycles + 100;

    localparam logic [fetch_pkg::xlen-1:0] train_pc     = 32'h0000_0040;
    localparam logic [fetch_pkg::xlen-1:0] train_target = 32'h0000_0200;

    logic                          clk;
    logic                          rst_n;
    logic                          out_valid;
    logic [fetch_pkg::xlen-1:0]    out_pc;
    logic [fetch_pkg::xlen-1:0]    out_inst;
    logic                          out_pred_taken;
    logic [fetch_pkg::xlen-1:0]    out_pred_target;
    logic                          out_is_ctrl;
    logic                          credit_return;
    logic                          update_valid;
    logic [fetch_pkg::xlen-1:0]    update_pc;
    logic                          update_taken;
    logic [fetch_pkg::xlen-1:0]    update_target;
    logic                          redirect_valid;
    logic [fetch_pkg::xlen-1:0]    redirect_pc;
    logic                          load_valid;
    logic [fetch_pkg::imem_aw-1:0] load_addr;
    logic [fetch_pkg::xlen-1:0]    load_data;

    // Stimulus for the next cycle
    logic                          nx_credit;
    logic                          nx_update;
    logic [fetch_pkg::xlen-1:0]    nx_update_pc;
    logic                          nx_update_taken;
    logic [fetch_pkg::xlen-1:0]    nx_update_target;
    logic                          nx_redirect;
    logic [fetch_pkg::xlen-1:0]    nx_redirect_pc;
    logic                          nx_load;
    logic [fetch_pkg::imem_aw-1:0] nx_load_addr;
    logic [fetch_pkg::xlen-1:0]    nx_load_data;

    // Reference model state
    logic [fetch_pkg::xlen-1:0]     mirror       [fetch_pkg::imem_depth];
    logic [1:0]                     m_ctr        [predict_pkg::bht_entries];
    logic                           m_btb_valid  [predict_pkg::btb_entries];
    logic [predict_pkg::btb_tw-1:0] m_btb_tag    [predict_pkg::btb_entries];
    logic [fetch_pkg::xlen-1:0]     m_btb_target [predict_pkg::btb_entries];
    logic [fetch_pkg::xlen-1:0]     m_pc;
    int                             m_credit;
    logic                           m_infl_valid;
    logic [fetch_pkg::xlen-1:0]     m_infl_pc;
    logic [fetch_pkg::xlen-1:0]     m_infl_inst;
    logic                           m_infl_pred;
    logic [fetch_pkg::xlen-1:0]     m_infl_target;

    integer seed;
    int     errors;
    int     delivered;
    int     hold_seen;
    logic   in_hold;
    logic   saw_trained;
    int     cycle_count = 0;

    fetch_top uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_inst        (out_inst),
        .out_pred_taken  (out_pred_taken),
        .out_pred_target (out_pred_target),
        .out_is_ctrl     (out_is_ctrl),
        .credit_return   (credit_return),
        .update_valid    (update_valid),
        .update_pc       (update_pc),
        .update_taken    (update_taken),
        .update_target   (update_target),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .load_valid      (load_valid),
        .load_addr       (load_addr),
        .load_data       (load_data)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check_pc(input string name, input logic [fetch_pkg::xlen-1:0] got,
                            input logic [fetch_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_inst(input string name, input logic [fetch_pkg::xlen-1:0] got,
                              input logic [fetch_pkg::xlen-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pred(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("Error: %s", msg);
    endtask

    // Roughly half the words carry a control-transfer opcode
    function automatic logic [fetch_pkg::xlen-1:0] random_word();
        logic [fetch_pkg::xlen-1:0] w;
        w = $random(seed);
        case (w[9:8])
            2'd0: w[6:0] = fetch_pkg::op_branch;
            2'd1: w[6:0] = fetch_pkg::op_jal;
            default: w[6:0] = w[6:0];
        endcase
        return w;
    endfunction

    // Small window of PCs so training and fetch meet often
    function automatic logic [fetch_pkg::xlen-1:0] random_pc();
        logic [fetch_pkg::xlen-1:0] r;
        r = $random(seed);
        return {24'd0, r[7:2], 2'b00};
    endfunction

    task automatic clear_stimulus();
        nx_credit        = 1'b0;
        nx_update        = 1'b0;
        nx_update_pc     = '0;
        nx_update_taken  = 1'b0;
        nx_update_target = '0;
        nx_redirect      = 1'b0;
        nx_redirect_pc   = '0;
        nx_load          = 1'b0;
        nx_load_addr     = '0;
        nx_load_data     = '0;
    endtask

    task automatic drive_inputs();
        credit_return  = nx_credit;
        update_valid   = nx_update;
        update_pc      = nx_update_pc;
        update_taken   = nx_update_taken;
        update_target  = nx_update_target;
        redirect_valid = nx_redirect;
        redirect_pc    = nx_redirect_pc;
        load_valid     = nx_load;
        load_addr      = nx_load_addr;
        load_data      = nx_load_data;
    endtask

    // One clock cycle: drive, check the settled outputs, advance the model
    task automatic run_cycle();
        logic                           exp_valid;
        logic                           exp_ctrl;
        logic                           issue;
        logic                           squash;
        logic                           hit;
        logic                           ptaken;
        logic [fetch_pkg::xlen-1:0]     pnext;
        logic [predict_pkg::bht_iw-1:0] bidx;
        logic [predict_pkg::btb_iw-1:0] tidx;
        logic [predict_pkg::bht_iw-1:0] uidx;
        logic [predict_pkg::btb_iw-1:0] utidx;
        @(negedge clk);
        drive_inputs();
        #5;
        exp_valid = m_infl_valid && !redirect_valid;
        exp_ctrl  = (m_infl_inst[6:0] == fetch_pkg::op_branch)
                 || (m_infl_inst[6:0] == fetch_pkg::op_jal);
        check_pred("out_valid", out_valid, exp_valid);
        if (exp_valid) begin
            check_pc("out_pc", out_pc, m_infl_pc);
            check_inst("out_inst", out_inst, m_infl_inst);
            check_pred("out_pred_taken", out_pred_taken, m_infl_pred);
            check_pc("out_pred_target", out_pred_target, m_infl_target);
            check_pred("out_is_ctrl", out_is_ctrl, exp_ctrl);
            delivered++;
            if (out_pc == train_pc && out_pred_taken) begin
                saw_trained = 1'b1;
            end
        end
        if (in_hold && out_valid) begin
            hold_seen++;
        end

        // Prediction needs a taken counter and a tag hit
        bidx   = m_pc[predict_pkg::bht_iw+1:2];
        tidx   = m_pc[predict_pkg::btb_iw+1:2];
        hit    = m_btb_valid[tidx]
              && (m_btb_tag[tidx] == m_pc[fetch_pkg::xlen-1:predict_pkg::btb_iw+2]);
        ptaken = (m_ctr[bidx] >= predict_pkg::ctr_taken_min) && hit;
        pnext  = ptaken ? m_btb_target[tidx] : m_pc + 32'd4;
        issue  = (m_credit != 0) && !redirect_valid && !load_valid;
        squash = m_infl_valid && redirect_valid;

        if (issue) begin
            m_infl_pc     = m_pc;
            m_infl_inst   = mirror[m_pc[fetch_pkg::imem_aw+1:2]];
            m_infl_pred   = ptaken;
            m_infl_target = pnext;
        end
        m_infl_valid = issue;
        m_credit = m_credit + int'(credit_return) + int'(squash) - int'(issue);
        if (redirect_valid) begin
            m_pc = redirect_pc;
        end else if (issue) begin
            m_pc = pnext;
        end
        if (credit_return) begin
            delivered--;
        end
        if (load_valid) begin
            mirror[load_addr] = load_data;
        end
        if (update_valid) begin
            uidx  = update_pc[predict_pkg::bht_iw+1:2];
            utidx = update_pc[predict_pkg::btb_iw+1:2];
            if (update_taken && m_ctr[uidx] != 2'b11) begin
                m_ctr[uidx] = m_ctr[uidx] + 2'd1;
            end else if (!update_taken && m_ctr[uidx] != 2'b00) begin
                m_ctr[uidx] = m_ctr[uidx] - 2'd1;
            end
            if (update_taken) begin
                m_btb_valid[utidx]  = 1'b1;
                m_btb_tag[utidx]    = update_pc[fetch_pkg::xlen-1:predict_pkg::btb_iw+2];
                m_btb_target[utidx] = update_target;
            end
        end
    endtask

    // Two outcomes on train_pc, a redirect onto it, then a few cycles to watch
    task automatic train_branch(input logic taken);
        for (int k = 0; k < 2; k++) begin
            clear_stimulus();
            nx_credit        = (delivered > 0);
            nx_update        = 1'b1;
            nx_update_pc     = train_pc;
            nx_update_taken  = taken;
            nx_update_target = train_target;
            run_cycle();
        end
        clear_stimulus();
        nx_credit      = (delivered > 0);
        nx_redirect    = 1'b1;
        nx_redirect_pc = train_pc;
        run_cycle();
        repeat (8) begin
            clear_stimulus();
            nx_credit = (delivered > 0);
            run_cycle();
        end
    endtask

    initial begin
        logic [31:0] roll;
        seed        = 42;
        errors      = 0;
        delivered   = 0;
        hold_seen   = 0;
        in_hold     = 1'b0;
        saw_trained = 1'b0;
        clear_stimulus();
        drive_inputs();

        for (int i = 0; i < int'(fetch_pkg::imem_depth); i++) begin
            mirror[i] = '0;
        end
        for (int i = 0; i < int'(predict_pkg::bht_entries); i++) begin
            m_ctr[i] = predict_pkg::ctr_weak_nt;
        end
        for (int i = 0; i < int'(predict_pkg::btb_entries); i++) begin
            m_btb_valid[i]  = 1'b0;
            m_btb_tag[i]    = '0;
            m_btb_target[i] = '0;
        end
        m_pc          = fetch_pkg::reset_pc;
        m_credit      = int'(fetch_pkg::fetch_credits);
        m_infl_valid  = 1'b0;
        m_infl_pc     = '0;
        m_infl_inst   = '0;
        m_infl_pred   = 1'b0;
        m_infl_target = '0;

        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_pred("out_valid", out_valid, 1'b0);
        rst_n = 1'b1;
        // First edge out of reset only enables fetch
        @(posedge clk);

        // Program load, fetch is held off the whole time
        for (int i = 0; i < load_cycles; i++) begin
            clear_stimulus();
            nx_load      = 1'b1;
            nx_load_addr = fetch_pkg::imem_aw'(i);
            nx_load_data = random_word();
            run_cycle();
        end

        // Untrained walk, credits handed back at once
        for (int i = 0; i < walk_cycles; i++) begin
            clear_stimulus();
            nx_credit = (delivered > 0);
            run_cycle();
        end

        in_hold = 1'b1;
        for (int i = 0; i < hold_cycles; i++) begin
            clear_stimulus();
            run_cycle();
        end
        in_hold = 1'b0;
        if (hold_seen > int'(fetch_pkg::fetch_credits)) begin
            report_error("more responses than credits while credits were withheld");
        end

        // One credit every eighth cycle
        for (int i = 0; i < drip_cycles; i++) begin
            clear_stimulus();
            nx_credit = (delivered > 0) && (i % 8 == 0);
            run_cycle();
        end

        train_branch(1'b1);
        if (!saw_trained) begin
            report_error("trained branch was never predicted taken");
        end
        train_branch(1'b0);

        for (int i = 0; i < random_cycles; i++) begin
            clear_stimulus();
            roll      = $random(seed);
            nx_credit = (delivered > 0) && (roll[1:0] != 2'd0);
            if (roll[4:2] == 3'd0) begin
                nx_update        = 1'b1;
                nx_update_pc     = random_pc();
                nx_update_taken  = roll[13] || roll[14];
                nx_update_target = random_pc();
            end
            if (roll[8:5] == 4'd0) begin
                nx_redirect    = 1'b1;
                nx_redirect_pc = random_pc();
            end
            if (roll[12:9] == 4'd0) begin
                nx_load      = 1'b1;
                nx_load_addr = roll[22:15];
                nx_load_data = random_word();
            end
            run_cycle();
        end

        $display("Run complete: %0d errors in %0d cycles", errors, cycle_count);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: source/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic                           clk,
    input  logic                           rst_n,
    // Decode side
    output logic                           out_valid,
    output logic [fetch_pkg::xlen-1:0]     out_pc,
    output logic [fetch_pkg::xlen-1:0]     out_inst,
    output logic                           out_pred_taken,
    output logic [fetch_pkg::xlen-1:0]     out_pred_target,
    output logic                           out_is_ctrl,
    input  logic                           credit_return,
    // Execute side
    input  logic                           update_valid,
    input  logic [fetch_pkg::xlen-1:0]     update_pc,
    input  logic                           update_taken,
    input  logic [fetch_pkg::xlen-1:0]     update_target,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::xlen-1:0]     redirect_pc,
    // Program load
    input  logic                           load_valid,
    input  logic [fetch_pkg::imem_aw-1:0]  load_addr,
    input  logic [fetch_pkg::xlen-1:0]     load_data
);

    logic                          fetch_req;
    logic [fetch_pkg::imem_aw-1:0] fetch_addr;
    logic                          fetch_grant;
    logic [fetch_pkg::xlen-1:0]    fetch_data;
    logic [fetch_pkg::xlen-1:0]    lookup_pc;
    logic                          pred_taken;
    logic                          btb_hit;
    logic [fetch_pkg::xlen-1:0]    btb_target;

    pc_gen u_pc_gen (
        .clk             (clk),
        .rst_n           (rst_n),
        .redirect_valid  (redirect_valid),
        .redirect_pc     (redirect_pc),
        .credit_return   (credit_return),
        .pred_taken      (pred_taken),
        .btb_hit         (btb_hit),
        .btb_target      (btb_target),
        .fetch_grant     (fetch_grant),
        .fetch_data      (fetch_data),
        .fetch_req       (fetch_req),
        .fetch_addr      (fetch_addr),
        .lookup_pc       (lookup_pc),
        .out_valid       (out_valid),
        .out_pc          (out_pc),
        .out_inst        (out_inst),
        .out_pred_taken  (out_pred_taken),
        .out_pred_target (out_pred_target),
        .out_is_ctrl     (out_is_ctrl)
    );

    branch_history u_branch_history (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_pc    (lookup_pc),
        .update_valid (update_valid),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .pred_taken   (pred_taken)
    );

    target_buffer u_target_buffer (
        .clk           (clk),
        .rst_n         (rst_n),
        .lookup_pc     (lookup_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .btb_hit       (btb_hit),
        .btb_target    (btb_target)
    );

    imem_arbiter u_imem_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .fetch_req   (fetch_req),
        .fetch_addr  (fetch_addr),
        .fetch_grant (fetch_grant),
        .fetch_data  (fetch_data)
    );

endmodule

// File: source/imem_arbiter.sv
`timescale 1ns/1ps

module imem_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load_valid,
    input  logic [fetch_pkg::imem_aw-1:0]  load_addr,
    input  logic [fetch_pkg::xlen-1:0]     load_data,
    input  logic                           fetch_req,
    input  logic [fetch_pkg::imem_aw-1:0]  fetch_addr,
    output logic                           fetch_grant,
    output logic [fetch_pkg::xlen-1:0]     fetch_data
);

    logic [fetch_pkg::xlen-1:0] mem [fetch_pkg::imem_depth];
    logic                       mem_we;
    logic                       mem_re;

    // Load port wins and fetch retries next cycle
    assign fetch_grant = fetch_req && !load_valid;

    assign mem_we = load_valid;
    assign mem_re = fetch_grant;

    // One access per cycle on the single port
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[load_addr] <= load_data;
        end
    end

    // Registered read with data valid the cycle after grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_data <= '0;
        end else if (mem_re) begin
            fetch_data <= mem[fetch_addr];
        end
    end

endmodule

// File: source/target_buffer.sv
`timescale 1ns/1ps

module target_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [fetch_pkg::xlen-1:0]  lookup_pc,
    input  logic                        update_valid,
    input  logic [fetch_pkg::xlen-1:0]  update_pc,
    input  logic                        update_taken,
    input  logic [fetch_pkg::xlen-1:0]  update_target,
    output logic                        btb_hit,
    output logic [fetch_pkg::xlen-1:0]  btb_target
);

    logic [predict_pkg::btb_entries-1:0] entry_valid;
    logic [predict_pkg::btb_tw-1:0]      entry_tag    [predict_pkg::btb_entries];
    logic [fetch_pkg::xlen-1:0]          entry_target [predict_pkg::btb_entries];

    logic [predict_pkg::btb_iw-1:0]      lookup_idx;
    logic [predict_pkg::btb_tw-1:0]      lookup_tag;
    logic [predict_pkg::btb_iw-1:0]      update_idx;
    logic [predict_pkg::btb_tw-1:0]      update_tag;
    logic                                write_en;

    // Index above the byte offset, tag is everything above the index
    assign lookup_idx = lookup_pc[predict_pkg::btb_iw+1:2];
    assign lookup_tag = lookup_pc[fetch_pkg::xlen-1:predict_pkg::btb_iw+2];
    assign update_idx = update_pc[predict_pkg::btb_iw+1:2];
    assign update_tag = update_pc[fetch_pkg::xlen-1:predict_pkg::btb_iw+2];

    // Only taken outcomes allocate
    assign write_en = update_valid && update_taken;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
        end else if (write_en) begin
            entry_valid[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            entry_tag[update_idx]    <= update_tag;
            entry_target[update_idx] <= update_target;
        end
    end

    assign btb_hit    = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);
    assign btb_target = entry_target[lookup_idx];

    a_target_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        btb_hit |-> btb_target[1:0] == 2'b00);

endmodule

// File: source/branch_history.sv
`timescale 1ns/1ps

module branch_history (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [fetch_pkg::xlen-1:0]  lookup_pc,
    input  logic                        update_valid,
    input  logic [fetch_pkg::xlen-1:0]  update_pc,
    input  logic                        update_taken,
    output logic                        pred_taken
);

    logic [1:0]                     ctr [predict_pkg::bht_entries];
    logic [predict_pkg::bht_iw-1:0] lookup_idx;
    logic [predict_pkg::bht_iw-1:0] update_idx;
    logic [1:0]                     update_ctr;

    assign lookup_idx = lookup_pc[predict_pkg::bht_iw+1:2];
    assign update_idx = update_pc[predict_pkg::bht_iw+1:2];
    assign update_ctr = ctr[update_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < predict_pkg::bht_entries; i++) begin
                ctr[i] <= predict_pkg::ctr_weak_nt;
            end
        end else if (update_valid) begin
            // Saturate at both ends
            if (update_taken) begin
                if (update_ctr != predict_pkg::ctr_strong_t) begin
                    ctr[update_idx] <= update_ctr + 2'd1;
                end
            end else begin
                if (update_ctr != predict_pkg::ctr_strong_nt) begin
                    ctr[update_idx] <= update_ctr - 2'd1;
                end
            end
        end
    end

    assign pred_taken = (ctr[lookup_idx] >= predict_pkg::ctr_taken_min);

endmodule

// File: source/pc_gen.sv
`timescale 1ns/1ps

module pc_gen (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           redirect_valid,
    input  logic [fetch_pkg::xlen-1:0]     redirect_pc,
    input  logic                           credit_return,
    input  logic                           pred_taken,
    input  logic                           btb_hit,
    input  logic [fetch_pkg::xlen-1:0]     btb_target,
    input  logic                           fetch_grant,
    input  logic [fetch_pkg::xlen-1:0]     fetch_data,
    output logic                           fetch_req,
    output logic [fetch_pkg::imem_aw-1:0]  fetch_addr,
    output logic [fetch_pkg::xlen-1:0]     lookup_pc,
    output logic                           out_valid,
    output logic [fetch_pkg::xlen-1:0]     out_pc,
    output logic [fetch_pkg::xlen-1:0]     out_inst,
    output logic                           out_pred_taken,
    output logic [fetch_pkg::xlen-1:0]     out_pred_target,
    output logic                           out_is_ctrl
);

    logic [fetch_pkg::xlen-1:0]     pc;
    logic [fetch_pkg::xlen-1:0]     pc_plus4;
    logic [fetch_pkg::xlen-1:0]     pred_next;
    logic [fetch_pkg::xlen-1:0]     pc_next;
    logic [fetch_pkg::credit_w-1:0] credit;
    logic                           fetch_en;
    logic                           pred_hit;
    logic                           issue;
    logic                           squash;

    // One-deep record of the read in flight
    logic                           inflight_valid;
    logic [fetch_pkg::xlen-1:0]     inflight_pc;
    logic                           inflight_pred_taken;
    logic [fetch_pkg::xlen-1:0]     inflight_pred_target;

    assign pc_plus4  = pc + fetch_pkg::xlen'(4);
    assign pred_hit  = pred_taken && btb_hit;
    assign pred_next = pred_hit ? btb_target : pc_plus4;

    // No fetch in the redirect cycle since the PC is about to change
    assign fetch_req = fetch_en && (credit != '0) && !redirect_valid;
    assign issue     = fetch_req && fetch_grant;
    assign squash    = inflight_valid && redirect_valid;

    assign fetch_addr = pc[fetch_pkg::imem_aw+1:2];
    assign lookup_pc  = pc;

    always_comb begin
        if (redirect_valid) begin
            pc_next = redirect_pc;
        end else if (issue) begin
            pc_next = pred_next;
        end else begin
            pc_next = pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc             <= fetch_pkg::reset_pc;
            credit         <= fetch_pkg::credit_w'(fetch_pkg::fetch_credits);
            fetch_en       <= 1'b0;
            inflight_valid <= 1'b0;
        end else begin
            pc             <= pc_next;
            // Squashed response gives its slot back
            credit         <= credit + fetch_pkg::credit_w'(credit_return)
                              + fetch_pkg::credit_w'(squash)
                              - fetch_pkg::credit_w'(issue);
            fetch_en       <= 1'b1;
            inflight_valid <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            inflight_pc          <= pc;
            inflight_pred_taken  <= pred_hit;
            inflight_pred_target <= pred_next;
        end
    end

    // Memory data lines up with the in-flight record
    assign out_valid       = inflight_valid && !redirect_valid;
    assign out_pc          = inflight_pc;
    assign out_inst        = fetch_data;
    assign out_pred_taken  = inflight_pred_taken;
    assign out_pred_target = inflight_pred_target;
    assign out_is_ctrl     = (fetch_data[fetch_pkg::opcode_w-1:0] == fetch_pkg::op_branch)
                          || (fetch_data[fetch_pkg::opcode_w-1:0] == fetch_pkg::op_jal);

    a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit <= fetch_pkg::credit_w'(fetch_pkg::fetch_credits));

endmodule

// File: source/predict_pkg.sv
package predict_pkg;

    // Branch history table, indexed by PC bits 7..2
    localparam int unsigned bht_entries = 64;
    localparam int unsigned bht_iw = 6;

    // Branch target buffer, indexed by PC bits 5..2
    localparam int unsigned btb_entries = 16;
    localparam int unsigned btb_iw = 4;

    // Tag is PC bits 31..6
    localparam int unsigned btb_tw = 26;

    // 2-bit saturating counter states
    localparam logic [1:0] ctr_strong_nt = 2'b00;
    localparam logic [1:0] ctr_weak_nt = 2'b01;
    localparam logic [1:0] ctr_strong_t = 2'b11;

    // At or above this value the branch is predicted taken
    localparam logic [1:0] ctr_taken_min = 2'b10;

endpackage

// File: source/fetch_pkg.sv
package fetch_pkg;

    // Datapath width for PC, instruction and branch target
    localparam int unsigned xlen = 32;

    // Instruction memory, one word per entry
    localparam int unsigned imem_depth = 256;

    // Word address is PC bits 9..2
    localparam int unsigned imem_aw = 8;

    // Decode buffer slots that fetch may fill
    localparam int unsigned fetch_credits = 4;

    // Wide enough to hold fetch_credits
    localparam int unsigned credit_w = 3;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // Opcode field, bits 6..0 of the instruction
    localparam int unsigned opcode_w = 7;

    // Conditional branches
    localparam logic [opcode_w-1:0] op_branch = 7'b1100011;

    // Unconditional jump and link
    localparam logic [opcode_w-1:0] op_jal = 7'b1101111;

endpackage
